//--- include/video_params.svh
/*
 * Shared constants for the composite sync and colour encoder.
 * Chip codes, luma levels, burst timing and pulse geometry.
 * Include this header in any module that needs one of these values.
 */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// chip codes, bit 0 set means a PAL part
`define CHIP_NTSC_R8         2'd0
`define CHIP_PAL_R3          2'd1
`define CHIP_NTSC_R56A       2'd2
`define CHIP_PAL_R1          2'd3

// luma levels
`define WHITE_BURST_LEVEL    6'h3b
`define BLANK_LEVEL_PAL      6'h08
`define BLANK_LEVEL_NTSC     6'h18

// horizontal sync always opens at column 10
`define HSYNC_START          10'd10

// half-line lengths and vertical pulse shapes, in columns
`define HALF_LINE_R8         10'd260
`define HALF_LINE_R56A       10'd256
`define HALF_LINE_PAL        10'd252
`define EQ_WIDTH             10'd19
`define SE_GAP               10'd38

// colour burst
`define BURST_AMPLITUDE      4'd12
`define BURST_START_PAL      10'd52
`define BURST_START_NTSC     10'd54
`define BURST_SAMPLES        8'd144
`define BURST_PHASE_NTSC     8'd128
`define BURST_PHASE_PAL_EVEN 8'd96
`define BURST_PHASE_PAL_ODD  8'd160

// chroma midpoint when nothing is modulated
`define CHROMA_ZERO          6'd32

`endif

//--- src/video_pkg.sv
/*
 * Types shared by the encoder blocks.
 * Raster position, pixel colour, per-chip window limits and the
 * registered sync decode that feeds the luma and chroma paths.
 */
package video_pkg;

    // selects one of the four chip variants
    typedef logic [1:0] chip_t;

    // raster coordinate as produced by the chip counters
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } raster_pos_t;

    // colour attributes of the pixel being drawn
    typedef struct packed {
        logic [5:0] luma;
        logic [7:0] phase;
        logic [3:0] amplitude;
    } pixel_color_t;

    // registered decode of one raster position
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       active;
        // index 0..9 of a vertical-blank line
        logic [3:0] vblank_line;
        logic       in_vblank;
        logic       at_first_pixel;
        logic       odd_line;
    } sync_state_t;

    // window limits for one chip
    typedef struct packed {
        logic [9:0] hvisible_start;
        logic [9:0] hvisible_end;
        logic [9:0] hsync_end;
        logic [8:0] vvisible_end;
        logic [8:0] vblank_start;
        logic [8:0] vvisible_start;
    } window_t;

endpackage

//--- src/raster_timing.sv
/*
 * Decodes the raster position into sync, blanking and visible flags.
 * The window limits follow the chip selection. All flags are
 * registered, one cycle behind pos.
 */
`include "video_params.svh"

module raster_timing import video_pkg::*; (
    input  logic        clk_col16x,
    input  logic        rst_n,
    input  raster_pos_t pos,
    input  chip_t       chip,
    output sync_state_t sync_state
);

    window_t win;
    logic    v_hidden;
    logic    h_outside;
    logic    in_vblank;

    // per-chip window limits
    always_comb begin
        case (chip)
            `CHIP_NTSC_R8: begin
                // 520x263
                win = '{hvisible_start: 10'd90, hvisible_end: 10'd510,
                        hsync_end: 10'd49, vvisible_end: 9'd13,
                        vblank_start: 9'd14, vvisible_start: 9'd23};
            end
            `CHIP_NTSC_R56A: begin
                // 512x262
                win = '{hvisible_start: 10'd90, hvisible_end: 10'd502,
                        hsync_end: 10'd48, vvisible_end: 9'd13,
                        vblank_start: 9'd14, vvisible_start: 9'd23};
            end
            default: begin
                // both PAL parts, 504x312
                win = '{hvisible_start: 10'd90, hvisible_end: 10'd494,
                        hsync_end: 10'd48, vvisible_end: 9'd300,
                        vblank_start: 9'd301, vvisible_start: 9'd310};
            end
        endcase
    end

    assign h_outside = pos.x >= win.hvisible_end || pos.x < win.hvisible_start;

    // the hidden band wraps across the frame boundary, starting part way
    // along the last visible line and ending at the first visible pixel
    assign v_hidden = ((pos.y == win.vvisible_end && pos.x < win.hvisible_end) ||
                       pos.y > win.vvisible_end) &&
                      ((pos.y == win.vvisible_start && pos.x <= win.hvisible_start) ||
                       pos.y < win.vvisible_start);

    assign in_vblank = pos.y >= win.vblank_start && pos.y <= win.vvisible_start;

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            sync_state <= '0;
        end else begin
            sync_state.hsync          <= pos.x >= `HSYNC_START && pos.x < win.hsync_end;
            sync_state.vsync          <= pos.y >= win.vvisible_end &&
                                         pos.y <= win.vvisible_start;
            sync_state.active         <= !(h_outside || v_hidden);
            sync_state.in_vblank      <= in_vblank;
            // line index within the blank band, only meaningful while in_vblank
            sync_state.vblank_line    <= 4'(pos.y - win.vblank_start);
            sync_state.at_first_pixel <= pos.x == win.hvisible_start;
            sync_state.odd_line       <= pos.y[0];
        end
    end

    // sync tip and picture never overlap for any chip
    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        !(sync_state.hsync && sync_state.active));

endmodule

//--- src/sync_pulse_gen.sv
/*
 * Equalization and serration pulse levels for the vertical interval.
 * Both repeat every half line, starting at the hsync column.
 * Outputs are registered, one cycle behind x.
 */
`include "video_params.svh"

module sync_pulse_gen import video_pkg::*; (
    input  logic       clk_col16x,
    input  logic       rst_n,
    input  logic [9:0] x,
    input  chip_t      chip,
    output logic       eq,
    output logic       se
);

    logic [9:0] half_line;
    logic [9:0] second_start;
    logic       in_first;
    logic       in_second;
    logic [9:0] first_ofs;
    logic [9:0] second_ofs;

    // half line in columns for each raster format
    always_comb begin
        case (chip)
            `CHIP_NTSC_R8:   half_line = `HALF_LINE_R8;
            `CHIP_NTSC_R56A: half_line = `HALF_LINE_R56A;
            default:         half_line = `HALF_LINE_PAL;
        endcase
    end

    assign second_start = `HSYNC_START + half_line;
    assign in_first     = x >= `HSYNC_START && x < second_start;
    assign in_second    = x >= second_start;
    // column offset from the start of the current half line
    assign first_ofs    = x - `HSYNC_START;
    assign second_ofs   = x - second_start;

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            eq <= 1'b0;
            se <= 1'b0;
        end else begin
            // narrow pulse at the head of each half line
            eq <= (in_first && first_ofs < `EQ_WIDTH) ||
                  (in_second && second_ofs < `EQ_WIDTH);
            // broad pulse, released for a short serration before the next half
            se <= (in_first && first_ofs < half_line - `SE_GAP) ||
                  (in_second && second_ofs < half_line - `SE_GAP);
        end
    end

    // column never runs past the second half line of the selected format
    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        x < second_start + half_line);

endmodule

//--- src/luma_gen.sv
/*
 * Luma code and sink strobe for each raster position.
 * Blank lines take the equalization, serration or hsync pulse,
 * other lines take sync, blanking, the white first pixel or the
 * pixel luma. The code leaves inverted for the sink-capable output.
 */
`include "video_params.svh"

module luma_gen import video_pkg::*; (
    input  logic         clk_col16x,
    input  logic         rst_n,
    input  sync_state_t  sync_state,
    input  logic         eq,
    input  logic         se,
    input  pixel_color_t color,
    input  chip_t        chip,
    input  logic         white_line,
    output logic [5:0]   luma_out,
    output logic         luma_sink
);

    logic [5:0] blank_level;
    logic [5:0] luma;
    logic       vpulse;

    // blanking sits lower on PAL parts
    assign blank_level = chip[0] ? `BLANK_LEVEL_PAL : `BLANK_LEVEL_NTSC;

    // which pulse drives each of the ten blank lines
    always_comb begin
        case (sync_state.vblank_line)
            4'd3, 4'd4, 4'd5: vpulse = se;
            // last blank line is an ordinary sync-only line
            4'd9:             vpulse = sync_state.hsync;
            default:          vpulse = eq;
        endcase
    end

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            luma      <= blank_level;
            luma_sink <= 1'b0;
        end else if (sync_state.in_vblank) begin
            luma      <= vpulse ? 6'd0 : blank_level;
            luma_sink <= vpulse;
        end else if (sync_state.hsync) begin
            luma      <= 6'd0;
            luma_sink <= 1'b1;
        end else begin
            luma_sink <= 1'b0;
            if (!sync_state.active) begin
                luma <= blank_level;
            end else if (sync_state.at_first_pixel && white_line) begin
                // the real chip leaves a white dot on the first visible column
                luma <= `WHITE_BURST_LEVEL;
            end else begin
                luma <= color.luma;
            end
        end
    end

    assign luma_out = ~luma;

endmodule

//--- src/chroma_gen.sv
/*
 * Chroma sample stream from a free-running phase counter and a sine ROM.
 * The counter steps the wave 16 times per colour period; the phase
 * offset shifts it and the amplitude picks one of 16 wave tables.
 * Burst runs for 145 samples after each line change. Output trails
 * sync_state by three cycles: address, ROM read, output register.
 */
`include "video_params.svh"

module chroma_gen import video_pkg::*; (
    input  logic         clk_col16x,
    input  logic         rst_n,
    input  sync_state_t  sync_state,
    input  logic [9:0]   x,
    input  pixel_color_t color,
    input  chip_t        chip,
    input  logic         white_line,
    input  logic         ntsc_50,
    input  logic         pal_60,
    output logic [11:0]  rom_addr,
    input  logic [8:0]   rom_data,
    output logic [5:0]   chroma_out
);

    logic [3:0] phase_count;
    logic [9:0] prev_x;
    logic       line_change;
    logic       need_burst;
    logic       in_burst;
    logic [7:0] burst_count;
    logic [9:0] burst_start;
    logic       pal_mode;
    logic       white_pixel;
    logic [7:0] pixel_phase;
    logic [3:0] pixel_amp;
    logic [3:0] amp_sel;
    logic [3:0] amp_d1;
    logic [3:0] amp_d2;
    logic [7:0] phase_offset;
    logic [7:0] wave_addr;

    // colour standard can be swapped independently of the raster format
    assign pal_mode    = chip[0] ? !ntsc_50 : pal_60;
    assign burst_start = chip[0] ? `BURST_START_PAL : `BURST_START_NTSC;

    // a new line begins when the column goes backwards
    assign line_change = x < prev_x;

    // white dot carries no colour
    assign white_pixel = sync_state.at_first_pixel && white_line;
    assign pixel_phase = white_pixel ? 8'd0 : color.phase;
    assign pixel_amp   = white_pixel ? 4'd0 : color.amplitude;

    // nothing during vsync, pixel colour in the window, burst level at the back porch
    always_comb begin
        if (sync_state.vsync) begin
            amp_sel = 4'd0;
        end else if (sync_state.active) begin
            amp_sel = pixel_amp;
        end else if (in_burst) begin
            amp_sel = `BURST_AMPLITUDE;
        end else begin
            amp_sel = 4'd0;
        end
    end

    // PAL mirrors the pixel phase and swings the burst +-135 deg on odd lines
    always_comb begin
        if (sync_state.active) begin
            if (pal_mode && sync_state.odd_line) begin
                phase_offset = 8'd255 - pixel_phase;
            end else begin
                phase_offset = pixel_phase;
            end
        end else if (pal_mode) begin
            phase_offset = sync_state.odd_line ? `BURST_PHASE_PAL_ODD : `BURST_PHASE_PAL_EVEN;
        end else begin
            phase_offset = `BURST_PHASE_NTSC;
        end
    end

    assign wave_addr = {phase_count, 4'b0000} + phase_offset;

    always_ff @(posedge clk_col16x) begin
        prev_x   <= x;
        // amplitude picks the table, wave position picks the entry
        rom_addr <= {amp_sel, wave_addr};
    end

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            phase_count <= 4'd0;
            need_burst  <= 1'b0;
            in_burst    <= 1'b0;
            burst_count <= 8'd0;
            amp_d1      <= 4'd0;
            amp_d2      <= 4'd0;
            chroma_out  <= `CHROMA_ZERO;
        end else begin
            phase_count <= phase_count + 4'd1;
            if (line_change) begin
                need_burst <= 1'b1;
            end
            if (x >= burst_start && need_burst) begin
                in_burst <= 1'b1;
            end
            if (in_burst) begin
                if (burst_count == `BURST_SAMPLES) begin
                    // nine colour periods done, wait for the next line
                    in_burst    <= 1'b0;
                    need_burst  <= 1'b0;
                    burst_count <= 8'd0;
                end else begin
                    burst_count <= burst_count + 8'd1;
                end
            end
            // amplitude follows the address and the ROM read
            amp_d1     <= amp_sel;
            amp_d2     <= amp_d1;
            chroma_out <= (amp_d2 == 4'd0) ? `CHROMA_ZERO : rom_data[8:3];
        end
    end

    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        burst_count <= `BURST_SAMPLES);

endmodule

//--- src/sine_table.sv
/*
 * Registered sine ROM, 16 amplitudes by 256 phases, 9-bit samples.
 * Each entry is centred on 256, so amplitude 0 is flat.
 * Address is {amplitude, phase}; data arrives one cycle later.
 */
module sine_table (
    input  logic        clk_col16x,
    input  logic [11:0] addr,
    output logic [8:0]  data
);

    localparam real TWO_PI = 6.283185307179586;

    logic [8:0] rom [4096];

    // table filled at elaboration, peak swing 15 * 16 stays inside 9 bits
    initial begin
        real wave;
        for (int a = 0; a < 16; a++) begin
            for (int p = 0; p < 256; p++) begin
                wave = $sin(TWO_PI * p / 256.0);
                rom[a * 256 + p] = 9'(256 + int'(a * 16.0 * wave));
            end
        end
    end

    always_ff @(posedge clk_col16x) begin
        data <= rom[addr];
    end

endmodule

//--- src/comp_sync.sv
/*
 * Composite sync and colour encoder top level.
 * Takes the raster position and pixel colour and drives the inverted
 * luma code with its sink strobe and the chroma sample stream.
 * Luma trails pos by two cycles, chroma by four.
 */
module comp_sync import video_pkg::*; (
    input  logic         clk_col16x,
    input  logic         rst_n,
    input  raster_pos_t  pos,
    input  pixel_color_t color,
    input  chip_t        chip,
    input  logic         white_line,
    input  logic         ntsc_50,
    input  logic         pal_60,
    output logic [5:0]   luma_out,
    output logic         luma_sink,
    output logic [5:0]   chroma_out
);

    sync_state_t sync_state;
    logic        eq;
    logic        se;
    logic [11:0] rom_addr;
    logic [8:0]  rom_data;

    raster_timing u_timing (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .pos        (pos),
        .chip       (chip),
        .sync_state (sync_state)
    );

    sync_pulse_gen u_pulses (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .x          (pos.x),
        .chip       (chip),
        .eq         (eq),
        .se         (se)
    );

    luma_gen u_luma (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .sync_state (sync_state),
        .eq         (eq),
        .se         (se),
        .color      (color),
        .chip       (chip),
        .white_line (white_line),
        .luma_out   (luma_out),
        .luma_sink  (luma_sink)
    );

    chroma_gen u_chroma (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .sync_state (sync_state),
        .x          (pos.x),
        .color      (color),
        .chip       (chip),
        .white_line (white_line),
        .ntsc_50    (ntsc_50),
        .pal_60     (pal_60),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .chroma_out (chroma_out)
    );

    sine_table u_sine (
        .clk_col16x (clk_col16x),
        .addr       (rom_addr),
        .data       (rom_data)
    );

endmodule

//--- bench/comp_sync_tb.sv
/*
 * Testbench for the composite sync and colour encoder.
 * Replays the raster steps of bench/comp_sync_trace.txt against the luma
 * code and sink, then watches the chroma stream for idle periods, burst
 * length and PAL line alternation. Run it from the project root.
 */
`include "video_params.svh"

module comp_sync_tb import video_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic         clk_col16x = 1'b0;
    logic         rst_n;
    raster_pos_t  pos;
    pixel_color_t color;
    chip_t        chip;
    logic         white_line;
    logic         ntsc_50;
    logic         pal_60;
    logic [5:0]   luma_out;
    logic         luma_sink;
    logic [5:0]   chroma_out;

    // posedge count, its low four bits track the free-running phase counter
    int           cycle = 0;
    int           seed;
    int           burst_span;
    logic [5:0]   period [16];
    logic [5:0]   burst_rec [16];
    logic [5:0]   prev_rec [16];

    comp_sync DUT (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .pos        (pos),
        .color      (color),
        .chip       (chip),
        .white_line (white_line),
        .ntsc_50    (ntsc_50),
        .pal_60     (pal_60),
        .luma_out   (luma_out),
        .luma_sink  (luma_sink),
        .chroma_out (chroma_out)
    );

    // 4 ns clock
    always #2 clk_col16x = ~clk_col16x;

    always @(posedge clk_col16x) begin
        cycle <= cycle + 1;
    end

    // inputs change and outputs are sampled on the falling edge
    task automatic step();
        @(negedge clk_col16x);
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort($sformatf("ERR %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp));
        end
    endtask

    task automatic run_trace();
        int         fd;
        int         rows;
        int         n;
        string      line;
        int         f_chip, f_x, f_y, f_luma;
        int         f_phase, f_amp, f_white;
        int         f_n50, f_p60, f_exp, f_sink;
        logic [5:0] exp_code;
        fd = $fopen("bench/comp_sync_trace.txt", "r");
        if (fd == 0) begin
            abort("the trace file bench/comp_sync_trace.txt could not be opened");
        end
        rows = 0;
        while ($fgets(line, fd) != 0) begin
            // comment and empty lines carry no step
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %h %h %h %d %d %d %h %d", f_chip, f_x, f_y,
                        f_luma, f_phase, f_amp, f_white, f_n50, f_p60, f_exp, f_sink);
            if (n != 11) begin
                abort($sformatf("trace line is malformed: %s", line));
            end
            rows++;
            step();
            chip            = chip_t'(f_chip);
            pos.x           = 10'(f_x);
            pos.y           = 9'(f_y);
            color.luma      = 6'(f_luma);
            color.phase     = 8'(f_phase);
            color.amplitude = 4'(f_amp);
            white_line      = f_white[0];
            ntsc_50         = f_n50[0];
            pal_60          = f_p60[0];
            // luma_out carries the inverted code
            exp_code        = ~6'(f_exp);
            step();
            // two clocks of latency, then the code holds for the rest of the step
            for (int i = 1; i < 24; i++) begin
                step();
                check(luma_out, exp_code, $sformatf("trace step %0d luma_out", rows));
                check(luma_sink, f_sink, $sformatf("trace step %0d luma_sink", rows));
            end
        end
        $fclose(fd);
        if (rows == 0) begin
            abort("the trace file holds no raster steps");
        end
    endtask

    task automatic record_period();
        for (int i = 0; i < 16; i++) begin
            step();
            period[i] = chroma_out;
        end
    endtask

    // waits for a full colour period of the zero level
    task automatic settle_to_zero();
        int run;
        int waited;
        run    = 0;
        waited = 0;
        while (run < 16) begin
            step();
            waited++;
            if (chroma_out == `CHROMA_ZERO) begin
                run++;
            end else begin
                run = 0;
            end
            if (waited > 200) begin
                abort("timeout: chroma never returned to its zero level");
            end
        end
    endtask

    task automatic observe_burst(input chip_t c, input logic [8:0] line);
        int waited;
        int first_cyc;
        int last_cyc;
        int quiet;
        int rec_n;
        // park in the back porch so a pending burst runs out
        step();
        chip            = c;
        color.amplitude = 4'd0;
        pos.x           = 10'd60;
        pos.y           = line;
        repeat (200) step();
        settle_to_zero();
        // column steps back, a new line arms the burst
        pos.x = 10'd20;
        repeat (4) step();
        pos.x  = 10'd60;
        waited = 0;
        while (chroma_out == `CHROMA_ZERO) begin
            step();
            waited++;
            if (waited > 16) begin
                abort("timeout: no colour burst after the line change");
            end
        end
        first_cyc = cycle;
        last_cyc  = cycle;
        quiet     = 0;
        rec_n     = 0;
        waited    = 0;
        while (quiet < 16) begin
            step();
            waited++;
            if (chroma_out != `CHROMA_ZERO) begin
                last_cyc = cycle;
                quiet    = 0;
            end else begin
                quiet++;
            end
            // one period taken at a fixed alignment of the phase counter
            if (rec_n < 16 && (rec_n > 0 || (cycle - first_cyc >= 16 && cycle % 16 == 0))) begin
                burst_rec[rec_n] = chroma_out;
                rec_n++;
            end
            if (waited > 400) begin
                abort("timeout: colour burst never ended");
            end
        end
        check(rec_n, 16, "burst samples recorded");
        burst_span = last_cyc - first_cyc + 1;
    endtask

    task automatic chroma_idle_tests();
        logic [5:0] lo;
        logic [5:0] hi;
        // vsync line, pixel amplitude is ignored
        step();
        chip            = `CHIP_NTSC_R8;
        pos.x           = 10'd100;
        pos.y           = 9'd17;
        color.luma      = 6'h20;
        color.phase     = 8'h40;
        color.amplitude = 4'd9;
        white_line      = 1'b0;
        repeat (5) step();
        record_period();
        for (int i = 0; i < 16; i++) begin
            check(period[i], `CHROMA_ZERO, "chroma during vsync");
        end
        // active window with amplitude 0
        step();
        pos.x           = 10'd200;
        pos.y           = 9'd60;
        color.amplitude = 4'd0;
        repeat (5) step();
        record_period();
        for (int i = 0; i < 16; i++) begin
            check(period[i], `CHROMA_ZERO, "chroma with zero amplitude");
        end
        // random non-zero colours have to swing over one period
        for (int t = 0; t < 4; t++) begin
            step();
            color.phase     = 8'($random(seed));
            color.amplitude = 4'(1 + $unsigned($random(seed)) % 15);
            repeat (5) step();
            record_period();
            lo = period[0];
            hi = period[0];
            for (int i = 1; i < 16; i++) begin
                if (period[i] < lo) lo = period[i];
                if (period[i] > hi) hi = period[i];
            end
            check(hi > lo, 1, $sformatf("chroma swing at amplitude %0d", color.amplitude));
        end
    endtask

    task automatic burst_tests();
        int diffs;
        // zero crossings may land on both ends and trim the visible span by two
        observe_burst(`CHIP_NTSC_R8, 9'd60);
        check(burst_span >= 143 && burst_span <= 146, 1,
              $sformatf("NTSC burst of %0d samples", burst_span));
        // same line, no rearm, so the back porch stays flat
        record_period();
        for (int i = 0; i < 16; i++) begin
            check(period[i], `CHROMA_ZERO, "chroma after the burst");
        end
        prev_rec = burst_rec;
        observe_burst(`CHIP_NTSC_R8, 9'd61);
        for (int i = 0; i < 16; i++) begin
            check(burst_rec[i], prev_rec[i], $sformatf("NTSC burst sample %0d", i));
        end
        // PAL swings between two burst phases on alternate lines
        observe_burst(`CHIP_PAL_R3, 9'd100);
        check(burst_span >= 143 && burst_span <= 146, 1,
              $sformatf("PAL burst of %0d samples", burst_span));
        prev_rec = burst_rec;
        observe_burst(`CHIP_PAL_R3, 9'd101);
        diffs = 0;
        for (int i = 0; i < 16; i++) begin
            if (burst_rec[i] != prev_rec[i]) diffs++;
        end
        check(diffs > 0, 1, "PAL burst alternation between even and odd lines");
    endtask

    initial begin
        logic [5:0] exp_code;
        seed       = 97765;
        rst_n      = 1'b0;
        pos        = '0;
        color      = '0;
        chip       = `CHIP_NTSC_R8;
        white_line = 1'b0;
        ntsc_50    = 1'b0;
        pal_60     = 1'b0;
        repeat (8) step();
        // reset values, still inside reset
        exp_code = ~`BLANK_LEVEL_NTSC;
        check(luma_sink, 0, "luma_sink in reset");
        check(luma_out, exp_code, "luma_out in reset");
        check(chroma_out, `CHROMA_ZERO, "chroma_out in reset");
        rst_n = 1'b1;
        run_trace();
        chroma_idle_tests();
        burst_tests();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- bench/comp_sync_trace.txt
# raster steps, each held 24 clocks: chip x y luma phase amp white_line ntsc_50 pal_60 exp_luma exp_sink
# chip x y flags exp_sink in decimal, luma phase amp exp_luma in hex, exp_luma before inversion
# pulse columns R8: eq 10-28 270-288, se 10-231 270-491; R56A: eq 10-28 266-284, se 10-227 266-483
# pulse columns PAL: eq 10-28 262-280, se 10-223 262-475; blank lines 0-2 6-8 eq, 3-5 se, 9 hsync
0 20 50 2a 00 0 0 0 0 00 1
0 48 50 2a 00 0 0 0 0 00 1
0 49 50 2a 00 0 0 0 0 18 0
0 90 50 2a 00 0 1 0 0 3b 0
0 90 50 2a 00 0 0 0 0 2a 0
0 300 50 15 40 3 0 0 0 15 0
0 509 50 33 00 0 0 0 0 33 0
0 510 50 33 00 0 0 0 0 18 0
0 5 50 33 00 0 0 0 0 18 0
2 47 100 0c 00 0 0 0 0 00 1
2 48 100 0c 00 0 0 0 0 18 0
2 90 100 0c 00 0 1 0 0 3b 0
2 501 100 0c 00 0 0 0 0 0c 0
2 502 100 0c 00 0 0 0 0 18 0
1 10 150 3f 00 0 0 0 0 00 1
1 60 150 3f 00 0 0 0 0 08 0
1 90 150 3f 00 0 1 0 0 3b 0
1 400 150 3f 80 5 0 0 0 3f 0
1 494 150 3f 00 0 0 0 0 08 0
3 30 200 21 00 0 0 0 0 00 1
3 100 200 21 00 0 0 0 0 21 0
0 15 14 2a 00 0 0 0 0 00 1
0 100 14 2a 00 0 0 0 0 18 0
0 275 14 2a 00 0 0 0 0 00 1
0 240 17 2a 00 0 0 0 0 18 0
0 300 17 2a 00 0 0 0 0 00 1
0 480 19 2a 00 0 0 0 0 00 1
0 495 19 2a 00 0 0 0 0 18 0
0 280 21 2a 00 0 0 0 0 00 1
0 30 23 2a 00 0 0 0 0 00 1
0 60 23 2a 00 0 0 0 0 18 0
1 270 301 2a 00 0 0 0 0 00 1
1 285 301 2a 00 0 0 0 0 08 0
1 230 304 2a 00 0 0 0 0 08 0
1 470 304 2a 00 0 0 0 0 00 1
1 40 310 2a 00 0 0 0 0 00 1
2 284 15 2a 00 0 0 0 0 00 1
2 227 18 2a 00 0 0 0 0 00 1
2 228 18 2a 00 0 0 0 0 18 0

//--- sources.f
+incdir+include
src/video_pkg.sv
src/raster_timing.sv
src/sync_pulse_gen.sv
src/luma_gen.sv
src/chroma_gen.sv
src/sine_table.sv
src/comp_sync.sv
bench/comp_sync_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the encoder and its testbench with Verilator, then run it
# the exit status of the run is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module comp_sync_tb -f sources.f &&
./obj_dir/Vcomp_sync_tb ||
{ echo "simulation failed"; exit 1; }
